// ==== hdl/hier_interco.sv ====
// One level of the interconnect tree
// Leaf level is a mux followed by an ID remapper
// Larger levels recurse over port slices and then over their outputs

`timescale 1ns/1ps

`include "hier_interco_params.svh"

module hier_interco #(
  // Must be a power of PORTS_PER_MUX
  parameter int unsigned NUM_SLV = `NUM_PORTS
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  interco_pkg::bus_req_t [NUM_SLV-1:0] slv_req_i,
  output logic                  [NUM_SLV-1:0] slv_req_ready_o,
  output interco_pkg::bus_rsp_t [NUM_SLV-1:0] slv_rsp_o,
  input  logic                  [NUM_SLV-1:0] slv_rsp_ready_i,
  output interco_pkg::bus_req_t               mst_req_o,
  input  logic                                mst_req_ready_i,
  input  interco_pkg::bus_rsp_t               mst_rsp_i,
  output logic                                mst_rsp_ready_o
);

  import interco_pkg::*;

  if (NUM_SLV == `PORTS_PER_MUX) begin : gen_leaf

    // Tagged channel between mux and remapper
    wide_req_t mux_req;
    logic      mux_req_ready;
    wide_rsp_t mux_rsp;
    logic      mux_rsp_ready;

    req_mux i_req_mux (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .slv_req_i       (slv_req_i),
      .slv_req_ready_o (slv_req_ready_o),
      .slv_rsp_o       (slv_rsp_o),
      .slv_rsp_ready_i (slv_rsp_ready_i),
      .mst_req_o       (mux_req),
      .mst_req_ready_i (mux_req_ready),
      .mst_rsp_i       (mux_rsp),
      .mst_rsp_ready_o (mux_rsp_ready)
    );

    id_remap i_id_remap (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .slv_req_i       (mux_req),
      .slv_req_ready_o (mux_req_ready),
      .slv_rsp_o       (mux_rsp),
      .slv_rsp_ready_i (mux_rsp_ready),
      .mst_req_o       (mst_req_o),
      .mst_req_ready_i (mst_req_ready_i),
      .mst_rsp_i       (mst_rsp_i),
      .mst_rsp_ready_o (mst_rsp_ready_o)
    );

  end else begin : gen_recurse

    localparam int unsigned NUM_MUX = NUM_SLV / `PORTS_PER_MUX;

    // Outputs of the lower sub-levels
    bus_req_t [NUM_MUX-1:0] sub_req;
    logic     [NUM_MUX-1:0] sub_req_ready;
    bus_rsp_t [NUM_MUX-1:0] sub_rsp;
    logic     [NUM_MUX-1:0] sub_rsp_ready;

    for (genvar g = 0; g < NUM_MUX; g++) begin : gen_sub
      hier_interco #(
        .NUM_SLV (`PORTS_PER_MUX)
      ) i_sub (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .slv_req_i       (slv_req_i[g*`PORTS_PER_MUX +: `PORTS_PER_MUX]),
        .slv_req_ready_o (slv_req_ready_o[g*`PORTS_PER_MUX +: `PORTS_PER_MUX]),
        .slv_rsp_o       (slv_rsp_o[g*`PORTS_PER_MUX +: `PORTS_PER_MUX]),
        .slv_rsp_ready_i (slv_rsp_ready_i[g*`PORTS_PER_MUX +: `PORTS_PER_MUX]),
        .mst_req_o       (sub_req[g]),
        .mst_req_ready_i (sub_req_ready[g]),
        .mst_rsp_i       (sub_rsp[g]),
        .mst_rsp_ready_o (sub_rsp_ready[g])
      );
    end

    // Upper level merges the sub-level outputs
    hier_interco #(
      .NUM_SLV (NUM_MUX)
    ) i_upper (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .slv_req_i       (sub_req),
      .slv_req_ready_o (sub_req_ready),
      .slv_rsp_o       (sub_rsp),
      .slv_rsp_ready_i (sub_rsp_ready),
      .mst_req_o       (mst_req_o),
      .mst_req_ready_i (mst_req_ready_i),
      .mst_rsp_i       (mst_rsp_i),
      .mst_rsp_ready_o (mst_rsp_ready_o)
    );

  end

endmodule

// ==== hdl/id_remap.sv ====
// Table-based compression of tagged IDs back to the port ID width
// Outstanding counter per table entry, entry freed at zero

`timescale 1ns/1ps

`include "hier_interco_params.svh"

module id_remap (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  interco_pkg::wide_req_t slv_req_i,
  output logic                   slv_req_ready_o,
  output interco_pkg::wide_rsp_t slv_rsp_o,
  input  logic                   slv_rsp_ready_i,
  output interco_pkg::bus_req_t  mst_req_o,
  input  logic                   mst_req_ready_i,
  input  interco_pkg::bus_rsp_t  mst_rsp_i,
  output logic                   mst_rsp_ready_o
);

  import interco_pkg::*;

  localparam int unsigned TABLE_N   = 2 ** `ID_W;
  localparam int unsigned WIDE_ID_W = `ID_W + `SEL_W;
  localparam int unsigned CNT_W     = $clog2(`MAX_TXNS_PER_ID + 1);

  // Remap table
  remap_state_e         state_q   [TABLE_N];
  logic [WIDE_ID_W-1:0] wide_id_q [TABLE_N];
  logic [CNT_W-1:0]     cnt_q     [TABLE_N];
  logic [CNT_W-1:0]     cnt_d     [TABLE_N];

  logic                 match_found;
  logic                 free_found;
  logic [`ID_W-1:0]     match_idx;
  logic [`ID_W-1:0]     free_idx;
  logic [`ID_W-1:0]     sel_idx;
  logic                 can_issue;

  // Pins the chosen entry while the downstream stalls
  logic                 hold_q;
  logic [`ID_W-1:0]     hold_idx_q;

  logic                 req_fire;
  logic                 rsp_fire;
  logic [`ID_W-1:0]     rsp_idx;

  ////////////////////////////////////////
  // Request path
  ////////////////////////////////////////

  // Reuse an entry with room for this ID, else the lowest free one
  always_comb begin
    match_found = 1'b0;
    match_idx   = '0;
    free_found  = 1'b0;
    free_idx    = '0;
    for (int i = 0; i < TABLE_N; i++) begin
      if (!match_found && state_q[i] == BUSY && wide_id_q[i] == slv_req_i.id &&
          cnt_q[i] < CNT_W'(`MAX_TXNS_PER_ID)) begin
        match_found = 1'b1;
        match_idx   = `ID_W'(i);
      end
      if (!free_found && state_q[i] == FREE) begin
        free_found = 1'b1;
        free_idx   = `ID_W'(i);
      end
    end
  end

  assign sel_idx   = hold_q ? hold_idx_q : (match_found ? match_idx : free_idx);
  assign can_issue = hold_q || match_found || free_found;

  always_comb begin
    mst_req_o.valid = slv_req_i.valid && can_issue;
    mst_req_o.addr  = slv_req_i.addr;
    mst_req_o.write = slv_req_i.write;
    mst_req_o.wdata = slv_req_i.wdata;
    mst_req_o.strb  = slv_req_i.strb;
    mst_req_o.id    = sel_idx;
  end

  assign slv_req_ready_o = mst_req_ready_i && can_issue;
  assign req_fire        = slv_req_i.valid && slv_req_ready_o;

  ////////////////////////////////////////
  // Response path
  ////////////////////////////////////////

  assign rsp_idx         = mst_rsp_i.id;
  assign mst_rsp_ready_o = slv_rsp_ready_i;
  assign rsp_fire        = mst_rsp_i.valid && slv_rsp_ready_i;

  always_comb begin
    slv_rsp_o.valid = mst_rsp_i.valid;
    slv_rsp_o.rdata = mst_rsp_i.rdata;
    slv_rsp_o.err   = mst_rsp_i.err;
    slv_rsp_o.id    = wide_id_q[rsp_idx];
  end

  ////////////////////////////////////////
  // Table update
  ////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < TABLE_N; i++) begin
      cnt_d[i] = cnt_q[i];
      if (req_fire && sel_idx == `ID_W'(i)) begin
        cnt_d[i] = cnt_d[i] + CNT_W'(1);
      end
      if (rsp_fire && rsp_idx == `ID_W'(i)) begin
        cnt_d[i] = cnt_d[i] - CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < TABLE_N; i++) begin
        state_q[i] <= FREE;
        cnt_q[i]   <= '0;
      end
      hold_q     <= 1'b0;
      hold_idx_q <= '0;
    end else begin
      for (int i = 0; i < TABLE_N; i++) begin
        cnt_q[i]   <= cnt_d[i];
        state_q[i] <= (cnt_d[i] == '0) ? FREE : BUSY;
      end
      hold_q <= mst_req_o.valid && !mst_req_ready_i;
      if (mst_req_o.valid && !mst_req_ready_i) begin
        hold_idx_q <= sel_idx;
      end
    end
  end

  // Stored wide ID, rewritten on every issue to the entry
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < TABLE_N; i++) begin
      if (req_fire && sel_idx == `ID_W'(i)) begin
        wide_id_q[i] <= slv_req_i.id;
      end
    end
  end

endmodule

// ==== hdl/interco_pkg.sv ====
// Channel structs for the request and response paths
// Wide variants used between mux and remapper
// Remap table entry state

`include "hier_interco_params.svh"

package interco_pkg;

  ////////////////////////////////////////
  // Port-width channels
  ////////////////////////////////////////

  // Request beat, address plus optional write data
  typedef struct packed {
    logic                   valid;
    logic [`ADDR_W-1:0]     addr;
    logic                   write;
    logic [`DATA_W-1:0]     wdata;
    logic [`DATA_W/8-1:0]   strb;
    logic [`ID_W-1:0]       id;
  } bus_req_t;

  // Response beat, read data is zero for writes
  typedef struct packed {
    logic                   valid;
    logic [`DATA_W-1:0]     rdata;
    logic                   err;
    logic [`ID_W-1:0]       id;
  } bus_rsp_t;

  ////////////////////////////////////////
  // Channels inside one tree level
  ////////////////////////////////////////

  // ID carries the input port tag in its low bits
  typedef struct packed {
    logic                       valid;
    logic [`ADDR_W-1:0]         addr;
    logic                       write;
    logic [`DATA_W-1:0]         wdata;
    logic [`DATA_W/8-1:0]       strb;
    logic [`ID_W+`SEL_W-1:0]    id;
  } wide_req_t;

  typedef struct packed {
    logic                       valid;
    logic [`DATA_W-1:0]         rdata;
    logic                       err;
    logic [`ID_W+`SEL_W-1:0]    id;
  } wide_rsp_t;

  typedef enum logic {
    FREE = 1'b0,
    BUSY = 1'b1
  } remap_state_e;

endpackage

// ==== hdl/interco_top.sv ====
// Top level with four requester ports and one memory port
// Two tree levels of two-input muxes

`timescale 1ns/1ps

`include "hier_interco_params.svh"

module interco_top (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  // Requester side
  input  interco_pkg::bus_req_t [`NUM_PORTS-1:0] req_i,
  output logic                  [`NUM_PORTS-1:0] req_ready_o,
  output interco_pkg::bus_rsp_t [`NUM_PORTS-1:0] rsp_o,
  input  logic                  [`NUM_PORTS-1:0] rsp_ready_i,
  // Memory side
  output interco_pkg::bus_req_t                  mem_req_o,
  input  logic                                   mem_req_ready_i,
  input  interco_pkg::bus_rsp_t                  mem_rsp_i,
  output logic                                   mem_rsp_ready_o
);

  import interco_pkg::*;

  hier_interco #(
    .NUM_SLV (`NUM_PORTS)
  ) i_hier_interco (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .slv_req_i       (req_i),
    .slv_req_ready_o (req_ready_o),
    .slv_rsp_o       (rsp_o),
    .slv_rsp_ready_i (rsp_ready_i),
    .mst_req_o       (mem_req_o),
    .mst_req_ready_i (mem_req_ready_i),
    .mst_rsp_i       (mem_rsp_i),
    .mst_rsp_ready_o (mem_rsp_ready_o)
  );

endmodule

// ==== hdl/req_mux.sv ====
// Round-robin merge of request channels into one tagged output
// One-beat spill register on the request path
// Response routing back to the input port by ID tag

`timescale 1ns/1ps

`include "hier_interco_params.svh"

module req_mux (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  interco_pkg::bus_req_t [`PORTS_PER_MUX-1:0] slv_req_i,
  output logic                  [`PORTS_PER_MUX-1:0] slv_req_ready_o,
  output interco_pkg::bus_rsp_t [`PORTS_PER_MUX-1:0] slv_rsp_o,
  input  logic                  [`PORTS_PER_MUX-1:0] slv_rsp_ready_i,
  output interco_pkg::wide_req_t                     mst_req_o,
  input  logic                                       mst_req_ready_i,
  input  interco_pkg::wide_rsp_t                     mst_rsp_i,
  output logic                                       mst_rsp_ready_o
);

  import interco_pkg::*;

  localparam int unsigned SEL_W     = `SEL_W;
  localparam int unsigned WIDE_ID_W = `ID_W + `SEL_W;

  // Arbiter
  logic [SEL_W-1:0] rr_q;
  logic [SEL_W-1:0] cand;
  logic [SEL_W-1:0] grant_idx;
  logic             req_found;

  // Spill register
  logic             spill_valid_q;
  wide_req_t        spill_q;
  wide_req_t        spill_d;
  logic             spill_ready;
  logic             accept;

  // Response routing
  logic [SEL_W-1:0] rsp_sel;

  ////////////////////////////////////////
  // Round-robin arbitration
  ////////////////////////////////////////

  // Search starts at the port after the last winner
  always_comb begin
    req_found = 1'b0;
    grant_idx = rr_q;
    cand      = rr_q;
    for (int i = 0; i < `PORTS_PER_MUX; i++) begin
      cand = rr_q + SEL_W'(i);
      if (!req_found && slv_req_i[cand].valid) begin
        req_found = 1'b1;
        grant_idx = cand;
      end
    end
  end

  // Free slot, or the held beat leaves this cycle
  assign spill_ready = !spill_valid_q || mst_req_ready_i;
  assign accept      = req_found && spill_ready;

  always_comb begin
    slv_req_ready_o            = '0;
    slv_req_ready_o[grant_idx] = accept;
  end

  // Tag goes below the requester's own ID
  always_comb begin
    spill_d.valid = 1'b1;
    spill_d.addr  = slv_req_i[grant_idx].addr;
    spill_d.write = slv_req_i[grant_idx].write;
    spill_d.wdata = slv_req_i[grant_idx].wdata;
    spill_d.strb  = slv_req_i[grant_idx].strb;
    spill_d.id    = {slv_req_i[grant_idx].id, grant_idx};
  end

  ////////////////////////////////////////
  // Spill register
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      spill_valid_q <= 1'b0;
      rr_q          <= '0;
    end else begin
      if (accept) begin
        spill_valid_q <= 1'b1;
        rr_q          <= grant_idx + SEL_W'(1);
      end else if (mst_req_ready_i) begin
        spill_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      spill_q <= spill_d;
    end
  end

  always_comb begin
    mst_req_o       = spill_q;
    mst_req_o.valid = spill_valid_q;
  end

  ////////////////////////////////////////
  // Response routing
  ////////////////////////////////////////

  assign rsp_sel = mst_rsp_i.id[SEL_W-1:0];

  // Strip the tag, hand the upper bits back as the port ID
  always_comb begin
    for (int i = 0; i < `PORTS_PER_MUX; i++) begin
      slv_rsp_o[i].valid = mst_rsp_i.valid && (rsp_sel == SEL_W'(i));
      slv_rsp_o[i].rdata = mst_rsp_i.rdata;
      slv_rsp_o[i].err   = mst_rsp_i.err;
      slv_rsp_o[i].id    = mst_rsp_i.id[WIDE_ID_W-1:SEL_W];
    end
  end

  assign mst_rsp_ready_o = slv_rsp_ready_i[rsp_sel];

endmodule

// ==== include/hier_interco_params.svh ====
// Global widths and fan-out of the hierarchical interconnect
// Per-ID transaction limit of the ID remapper

`ifndef HIER_INTERCO_PARAMS_SVH
`define HIER_INTERCO_PARAMS_SVH

// Bus payload widths
`define ADDR_W 16
`define DATA_W 32

// Transaction ID width seen on every requester-side port
`define ID_W 2

// Tree shape
`define PORTS_PER_MUX 2
// log2 of PORTS_PER_MUX, the tag added by each mux
`define SEL_W 1
`define NUM_PORTS 4

// Outstanding transactions one narrow ID may carry
`define MAX_TXNS_PER_ID 4

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator, run, and look for the pass message in the output
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
  --top-module tb_interco_top \
  -f vlog.f

out=$(./obj_dir/Vtb_interco_top +verilator+error+limit+100)
echo "$out"

if echo "$out" | grep -q "^All checks passed$"; then
  exit 0
fi
exit 1

// ==== testbench/interco_properties.sv ====
// Handshake assertions on the top-level ports of the interconnect
// Attached to interco_top by bind

`timescale 1ns/1ps

`include "hier_interco_params.svh"

module interco_properties (
  input logic                                   clk_i,
  input logic                                   rst_n_i,
  input interco_pkg::bus_rsp_t [`NUM_PORTS-1:0] rsp_o,
  input logic                  [`NUM_PORTS-1:0] rsp_ready_i,
  input interco_pkg::bus_req_t                  mem_req_o,
  input logic                                   mem_req_ready_i,
  input logic                                   mem_rsp_ready_o
);

  // Longest run of cycles with the memory response ready low
  localparam int unsigned RSP_READY_BOUND = 64;

  int unsigned fail_cnt = 0;
  int unsigned low_cnt;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      low_cnt <= 0;
    end else if (mem_rsp_ready_o) begin
      low_cnt <= 0;
    end else begin
      low_cnt <= low_cnt + 1;
    end
  end

  ////////////////////////////////////////
  // Memory side
  ////////////////////////////////////////

  mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_o.valid && !mem_req_ready_i |=> $stable(mem_req_o))
    else begin
      $error("mem_req_o changed while waiting for ready");
      fail_cnt++;
    end

  mem_req_idle_in_reset: assert property (@(posedge clk_i)
    !rst_n_i |-> !mem_req_o.valid)
    else begin
      $error("mem_req_o valid high during reset");
      fail_cnt++;
    end

  rsp_ready_bounded: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    low_cnt < RSP_READY_BOUND)
    else begin
      $error("mem_rsp_ready_o held low too long");
      fail_cnt++;
    end

  ////////////////////////////////////////
  // Requester side
  ////////////////////////////////////////

  for (genvar p = 0; p < `NUM_PORTS; p++) begin : gen_port
    rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rsp_o[p].valid && !rsp_ready_i[p] |=> $stable(rsp_o[p]))
      else begin
        $error("rsp_o[%0d] changed while waiting for ready", p);
        fail_cnt++;
      end

    rsp_idle_in_reset: assert property (@(posedge clk_i)
      !rst_n_i |-> !rsp_o[p].valid)
      else begin
        $error("rsp_o[%0d] valid high during reset", p);
        fail_cnt++;
      end
  end

endmodule

bind interco_top interco_properties u_props (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .rsp_o           (rsp_o),
  .rsp_ready_i     (rsp_ready_i),
  .mem_req_o       (mem_req_o),
  .mem_req_ready_i (mem_req_ready_i),
  .mem_rsp_ready_o (mem_rsp_ready_o)
);

// ==== testbench/tb_interco_top.sv ====
// Testbench for interco_top with an in-order memory model
// Table of requests per port and test with per-port response checks

`timescale 1ns/1ps

`include "hier_interco_params.svh"

module tb_interco_top;

  import interco_pkg::*;

  localparam int HS_TIMEOUT    = 200;
  localparam int DRAIN_TIMEOUT = 500;
  localparam int STALL_CYCLES  = 10;

  typedef struct packed {
    int                 test;
    int                 phase;
    int                 port;
    logic               write;
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] data;
    logic [`DATA_W-1:0] exp;
    logic [`ID_W-1:0]   id;
  } step_t;

  logic                         clk_i;
  logic                         rst_n_i;
  bus_req_t [`NUM_PORTS-1:0]    req_i;
  logic     [`NUM_PORTS-1:0]    req_ready_o;
  bus_rsp_t [`NUM_PORTS-1:0]    rsp_o;
  logic     [`NUM_PORTS-1:0]    rsp_ready_i;
  bus_req_t                     mem_req_o;
  logic                         mem_req_ready_i;
  bus_rsp_t                     mem_rsp_i;
  logic                         mem_rsp_ready_o;

  step_t                        steps[$];
  logic [`ID_W+`DATA_W-1:0]     exp_q[`NUM_PORTS][$];
  logic [`DATA_W-1:0]           mem[256];
  bus_rsp_t                     rsp_q[$];
  int                           seed;
  logic                         bp_en;
  logic                         rsp_hold;
  int unsigned                  err_cnt;
  int unsigned                  chk_cnt;

  interco_top UUT (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .req_i           (req_i),
    .req_ready_o     (req_ready_o),
    .rsp_o           (rsp_o),
    .rsp_ready_i     (rsp_ready_i),
    .mem_req_o       (mem_req_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_i       (mem_rsp_i),
    .mem_rsp_ready_o (mem_rsp_ready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
      err_cnt++;
    end
  endtask

  function automatic void add_step(input int test, input int phase, input int port,
                                   input logic write, input logic [`ADDR_W-1:0] addr,
                                   input logic [`DATA_W-1:0] data,
                                   input logic [`DATA_W-1:0] exp, input logic [`ID_W-1:0] id);
    steps.push_back({test, phase, port, write, addr, data, exp, id});
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int p = 0; p < `NUM_PORTS; p++) begin
      n += exp_q[p].size();
    end
    return n;
  endfunction

  ////////////////////////////////////////
  // Requester drivers and response checks
  ////////////////////////////////////////

  // Sends the table rows of one port one beat at a time
  task automatic drive_port(input int p, input int t, input int ph);
    int cyc;
    for (int i = 0; i < steps.size(); i++) begin
      if (steps[i].test == t && steps[i].phase == ph && steps[i].port == p) begin
        exp_q[p].push_back({steps[i].id, steps[i].exp});
        req_i[p].valid = 1'b1;
        req_i[p].addr  = steps[i].addr;
        req_i[p].write = steps[i].write;
        req_i[p].wdata = steps[i].data;
        req_i[p].strb  = '1;
        req_i[p].id    = steps[i].id;
        cyc = 0;
        @(negedge clk_i);
        while (!req_ready_o[p] && cyc < HS_TIMEOUT) begin
          @(negedge clk_i);
          cyc++;
        end
        if (!req_ready_o[p]) begin
          $display("Timeout: port %0d request was never accepted", p);
          err_cnt++;
          void'(exp_q[p].pop_back());
        end
        @(posedge clk_i);
        #1;
      end
    end
    req_i[p] = '0;
  endtask

  task automatic wait_drain();
    int cyc;
    cyc = 0;
    while (outstanding() > 0 && cyc < DRAIN_TIMEOUT) begin
      @(posedge clk_i);
      cyc++;
    end
    #1;
    if (outstanding() > 0) begin
      $display("Timeout: %0d responses never arrived", outstanding());
      err_cnt++;
    end
  endtask

  // A beat seen here transfers on the next rising edge
  always @(negedge clk_i) begin : collect
    logic [`ID_W+`DATA_W-1:0] e;
    for (int p = 0; p < `NUM_PORTS; p++) begin
      if (rst_n_i && rsp_o[p].valid && rsp_ready_i[p]) begin
        if (exp_q[p].size() == 0) begin
          $display("Unexpected response on port %0d", p);
          err_cnt++;
        end else begin
          e = exp_q[p].pop_front();
          check($sformatf("rsp_o[%0d].rdata", p), rsp_o[p].rdata, e[`DATA_W-1:0]);
          check($sformatf("rsp_o[%0d].id", p), rsp_o[p].id, e[`ID_W+`DATA_W-1:`DATA_W]);
          check($sformatf("rsp_o[%0d].err", p), rsp_o[p].err, 0);
        end
      end
    end
  end

  ////////////////////////////////////////
  // In-order memory model
  ////////////////////////////////////////

  initial begin : mem_model
    bus_req_t   req_s;
    bus_rsp_t   rsp_n;
    logic       req_fire;
    logic       rsp_fire;
    logic       bp_s;
    logic       hold_s;
    logic [7:0] idx;
    int         rnd;
    forever begin
      @(negedge clk_i);
      req_fire = mem_req_o.valid && mem_req_ready_i;
      rsp_fire = mem_rsp_i.valid && mem_rsp_ready_o;
      req_s    = mem_req_o;
      bp_s     = bp_en;
      hold_s   = rsp_hold;
      @(posedge clk_i);
      #1;
      if (rsp_fire) begin
        void'(rsp_q.pop_front());
      end
      if (req_fire) begin
        idx         = req_s.addr[9:2];
        rsp_n       = '0;
        rsp_n.valid = 1'b1;
        rsp_n.id    = req_s.id;
        if (req_s.write) begin
          for (int b = 0; b < `DATA_W/8; b++) begin
            if (req_s.strb[b]) begin
              mem[idx][8*b +: 8] = req_s.wdata[8*b +: 8];
            end
          end
        end else begin
          rsp_n.rdata = mem[idx];
        end
        rsp_q.push_back(rsp_n);
      end
      mem_rsp_i = (rsp_q.size() > 0 && !hold_s) ? rsp_q[0] : '0;
      rnd = $random(seed);
      mem_req_ready_i = bp_s ? rnd[0] : 1'b1;
      rnd = $random(seed);
      rsp_ready_i = bp_s ? rnd[`NUM_PORTS-1:0] : '1;
    end
  end

  ////////////////////////////////////////
  // Stimulus table and test sequence
  ////////////////////////////////////////

  initial begin : main
    int unsigned             errs_before;
    logic [`NUM_PORTS-1:0]   rsp_valid;
    logic [`ADDR_W-1:0]      a;
    logic [`DATA_W-1:0]      d;
    rst_n_i         = 1'b0;
    req_i           = '0;
    rsp_ready_i     = '1;
    mem_req_ready_i = 1'b1;
    mem_rsp_i       = '0;
    bp_en           = 1'b0;
    rsp_hold        = 1'b0;
    seed            = 61;
    err_cnt         = 0;
    chk_cnt         = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'h5A5A_0000 | (i * 32'h0000_0101);
    end

    // Write then read on one port
    add_step(2, 0, 0, 1'b1, 16'h0010, 32'h1234_5678, 32'h0, 2'd0);
    add_step(2, 0, 0, 1'b0, 16'h0010, 32'h0, 32'h1234_5678, 2'd0);
    // Distinct writes followed by crosswise reads of the neighbour's word
    add_step(3, 0, 0, 1'b1, 16'h0100, 32'hA000_0001, 32'h0, 2'd0);
    add_step(3, 0, 1, 1'b1, 16'h0104, 32'hB000_0002, 32'h0, 2'd1);
    add_step(3, 0, 2, 1'b1, 16'h0108, 32'hC000_0003, 32'h0, 2'd2);
    add_step(3, 0, 3, 1'b1, 16'h010C, 32'hD000_0004, 32'h0, 2'd3);
    add_step(3, 1, 0, 1'b0, 16'h0104, 32'h0, 32'hB000_0002, 2'd0);
    add_step(3, 1, 1, 1'b0, 16'h0108, 32'h0, 32'hC000_0003, 2'd1);
    add_step(3, 1, 2, 1'b0, 16'h010C, 32'h0, 32'hD000_0004, 2'd2);
    add_step(3, 1, 3, 1'b0, 16'h0100, 32'h0, 32'hA000_0001, 2'd3);
    // All ports at once with the same ID
    for (int p = 0; p < `NUM_PORTS; p++) begin
      a = 16'h0200 + 16'(p * 16);
      d = 32'h4000_0000 + 32'(p * 256);
      add_step(4, 0, p, 1'b1, a, d, 32'h0, 2'd1);
      add_step(4, 0, p, 1'b1, a + 16'd4, d + 32'd1, 32'h0, 2'd1);
      add_step(4, 0, p, 1'b0, a, 32'h0, d, 2'd1);
      add_step(4, 0, p, 1'b0, a + 16'd4, 32'h0, d + 32'd1, 2'd1);
    end
    // More than MAX_TXNS_PER_ID in flight on one ID
    for (int k = 0; k < 3; k++) begin
      add_step(5, 0, 1, 1'b1, 16'h0300 + 16'(k * 4), 32'h5000_0000 + 32'(k), 32'h0, 2'd3);
    end
    for (int k = 0; k < 3; k++) begin
      add_step(5, 0, 1, 1'b0, 16'h0300 + 16'(k * 4), 32'h0, 32'h5000_0000 + 32'(k), 2'd3);
    end

    repeat (2) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    @(negedge clk_i);
    for (int p = 0; p < `NUM_PORTS; p++) begin
      rsp_valid[p] = rsp_o[p].valid;
    end
    check("rsp_o.valid", rsp_valid, 0);
    check("mem_req_o.valid", mem_req_o.valid, 0);
    $display("Test 1: %0d errors", err_cnt);
    @(posedge clk_i);
    #1;

    for (int t = 2; t <= 5; t++) begin
      errs_before = err_cnt;
      bp_en = (t == 4);
      for (int ph = 0; ph < 2; ph++) begin
        rsp_hold = (t == 5 && ph == 0);
        fork
          drive_port(0, t, ph);
          drive_port(1, t, ph);
          drive_port(2, t, ph);
          drive_port(3, t, ph);
        join
        if (rsp_hold) begin
          repeat (STALL_CYCLES) @(posedge clk_i);
          #1;
          rsp_hold = 1'b0;
        end
        wait_drain();
      end
      bp_en = 1'b0;
      $display("Test %0d: %0d errors", t, err_cnt - errs_before);
    end

    repeat (5) @(posedge clk_i);
    #1;
    check("mem_rsp_queue_size", rsp_q.size(), 0);
    check("assert_fail_cnt", UUT.u_props.fail_cnt, 0);
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+include
hdl/interco_pkg.sv
hdl/req_mux.sv
hdl/id_remap.sv
hdl/hier_interco.sv
hdl/interco_top.sv
testbench/interco_properties.sv
testbench/tb_interco_top.sv
